/* design/blimp_pkg.sv */
//----------------------------------------------------------------------
// Blimp core shared definitions
// Widths, opcodes, reset vector, instruction views and port structs
//----------------------------------------------------------------------

`default_nettype none

package blimp_pkg;

  //--------------------------------------------------------------------
  // Widths and constants
  //--------------------------------------------------------------------

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned mul_steps  = 32;

  // First fetch address after reset
  localparam logic [xlen-1:0] reset_vector = 32'h0000_0200;

  // Major opcodes
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;

  // funct7 splits ADD from MUL under op_reg
  localparam logic [6:0] funct7_add = 7'b0000000;
  localparam logic [6:0] funct7_mul = 7'b0000001;
  localparam logic [2:0] funct3_add = 3'b000;

  //--------------------------------------------------------------------
  // Instruction word views
  //--------------------------------------------------------------------

  // R-type, used by ADD and MUL
  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } inst_r_t;

  // I-type, used by ADDI
  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } inst_i_t;

  // One fetched word, read through either view
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_t;

  //--------------------------------------------------------------------
  // Port bundles
  //--------------------------------------------------------------------

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] data;
  } imem_resp_t;

  // One pulse per retired instruction
  typedef struct packed {
    logic                  val;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
    logic                  wen;
  } trace_t;

  typedef enum logic [2:0] {
    s_fetch,
    s_wait,
    s_exec,
    s_mul,
    s_retire
  } ctrl_state_t;

endpackage

`default_nettype wire

/* design/blimp_ctrl.sv */
//----------------------------------------------------------------------
// Blimp control FSM
// Sequences fetch, wait, execute, multiply and retire; owns the PC
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          imem_req_ready,
  input  logic                          resp_valid,
  input  logic                          is_mul,
  input  logic                          mul_done,
  output blimp_pkg::ctrl_state_t        state,
  output blimp_pkg::imem_req_t          imem_req,
  output logic                          ir_load,
  output logic                          mul_start,
  output logic                          retire,
  output logic [blimp_pkg::xlen-1:0]    pc
);

  blimp_pkg::ctrl_state_t state_next;
  logic                   req_valid;
  logic                   req_fire;

  assign req_fire = req_valid && imem_req_ready;

  //--------------------------------------------------------------------
  // State register and next state
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= blimp_pkg::s_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      blimp_pkg::s_fetch:  if (req_fire) state_next = blimp_pkg::s_wait;
      blimp_pkg::s_wait:   if (resp_valid) state_next = blimp_pkg::s_exec;
      // Multiplies detour through s_mul
      blimp_pkg::s_exec:   state_next = is_mul ? blimp_pkg::s_mul : blimp_pkg::s_retire;
      blimp_pkg::s_mul:    if (mul_done) state_next = blimp_pkg::s_retire;
      blimp_pkg::s_retire: state_next = blimp_pkg::s_fetch;
      default:             state_next = blimp_pkg::s_fetch;
    endcase
  end

  //--------------------------------------------------------------------
  // Request valid and PC
  //--------------------------------------------------------------------

  // Low for the first cycle after reset, then rises in s_fetch;
  // after a retire it rises in the following cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else if (state == blimp_pkg::s_fetch && req_fire) begin
      req_valid <= 1'b0;
    end else if (state == blimp_pkg::s_fetch || state == blimp_pkg::s_retire) begin
      req_valid <= 1'b1;
    end
  end

  // Sequential PC only
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= blimp_pkg::reset_vector;
    end else if (retire) begin
      pc <= pc + blimp_pkg::xlen'(4);
    end
  end

  always_comb begin
    imem_req.valid = req_valid;
    imem_req.addr  = pc;
  end

  // Strobes to the datapath
  assign ir_load   = (state == blimp_pkg::s_wait) && resp_valid;
  assign mul_start = (state == blimp_pkg::s_exec) && is_mul;
  assign retire    = (state == blimp_pkg::s_retire);

  //--------------------------------------------------------------------
  // Assertions
  //--------------------------------------------------------------------

  // Multiplier finishes only while we wait on it
  a_mul_done_in_mul: assert property (@(posedge clk) disable iff (reset)
    mul_done |-> state == blimp_pkg::s_mul);

  // Request held with a stable address until it transfers
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    imem_req.valid && !imem_req_ready |=> imem_req.valid && $stable(imem_req.addr));

endmodule

`default_nettype wire

/* design/blimp_mul.sv */
//----------------------------------------------------------------------
// Blimp iterative multiplier
// Shift-add over mul_steps cycles, low 32 bits of the product
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_mul (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic [blimp_pkg::xlen-1:0] a,
  input  logic [blimp_pkg::xlen-1:0] b,
  output logic                       done,
  output logic [blimp_pkg::xlen-1:0] product
);

  // Multiplicand shifts left, multiplier shifts right
  logic [blimp_pkg::xlen-1:0] mcand;
  logic [blimp_pkg::xlen-1:0] mplier;
  logic [blimp_pkg::xlen-1:0] acc;

  // Steps left; zero means idle
  logic [5:0] count;
  logic       busy;

  assign busy = (count != 6'd0);

  //--------------------------------------------------------------------
  // Step counter
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 6'd0;
    end else if (start) begin
      count <= 6'(blimp_pkg::mul_steps);
    end else if (busy) begin
      count <= count - 6'd1;
    end
  end

  // Last step runs this cycle, so acc is final at the next edge
  assign done = (count == 6'd1);

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
    end else if (busy) begin
      // Add partial product when low bit set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign product = acc;

  //--------------------------------------------------------------------
  // Assertions
  //--------------------------------------------------------------------

  // No restart while an operation is in flight
  a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy);

  // Done lands mul_steps cycles after start
  a_done_timing: assert property (@(posedge clk) disable iff (reset)
    start |-> ##(blimp_pkg::mul_steps) done);

endmodule

`default_nettype wire

/* design/blimp_regfile.sv */
//----------------------------------------------------------------------
// Blimp register file
// 31 storage registers, x0 reads zero; 2 read ports, 1 write port
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_regfile (
  input  logic                             clk,
  input  logic [blimp_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [blimp_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [blimp_pkg::xlen-1:0]       rs1_data,
  output logic [blimp_pkg::xlen-1:0]       rs2_data,
  input  logic                             we,
  input  logic [blimp_pkg::reg_addr_w-1:0] waddr,
  input  logic [blimp_pkg::xlen-1:0]       wdata
);

  // No storage behind x0
  logic [blimp_pkg::xlen-1:0] regs [1:31];

  // Write at the clock edge
  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

`default_nettype wire

/* design/blimp_exec.sv */
//----------------------------------------------------------------------
// Blimp execute block
// Instruction register, decode, operand select and ADD/ADDI adder
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_exec (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             ir_load,
  input  logic                             retire,
  input  blimp_pkg::ctrl_state_t           state,
  input  blimp_pkg::inst_t                 resp_data,
  input  logic [blimp_pkg::xlen-1:0]       rs1_data,
  input  logic [blimp_pkg::xlen-1:0]       rs2_data,
  input  logic [blimp_pkg::xlen-1:0]       product,
  output logic [blimp_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [blimp_pkg::reg_addr_w-1:0] rs2_addr,
  output logic                             is_mul,
  output logic [blimp_pkg::xlen-1:0]       mul_a,
  output logic [blimp_pkg::xlen-1:0]       mul_b,
  output logic                             rf_we,
  output logic [blimp_pkg::reg_addr_w-1:0] waddr,
  output logic [blimp_pkg::xlen-1:0]       wdata
);

  blimp_pkg::inst_t           ir;
  logic                       is_add;
  logic                       is_addi;
  logic                       supported;
  logic [blimp_pkg::xlen-1:0] imm;
  logic [blimp_pkg::xlen-1:0] opnd_b;
  logic [blimp_pkg::xlen-1:0] sum;

  // Loaded on the response strobe
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir <= resp_data;
    end
  end

  //--------------------------------------------------------------------
  // Decode
  //--------------------------------------------------------------------

  // Register view for ADD/MUL
  assign is_add = (ir.r.opcode == blimp_pkg::op_reg) && (ir.r.funct3 == blimp_pkg::funct3_add)
               && (ir.r.funct7 == blimp_pkg::funct7_add);
  assign is_mul = (ir.r.opcode == blimp_pkg::op_reg) && (ir.r.funct3 == blimp_pkg::funct3_add)
               && (ir.r.funct7 == blimp_pkg::funct7_mul);
  // Immediate view for ADDI
  assign is_addi = (ir.i.opcode == blimp_pkg::op_imm) && (ir.i.funct3 == blimp_pkg::funct3_add);
  assign supported = is_add || is_addi || is_mul;

  assign imm      = {{(blimp_pkg::xlen-12){ir.i.imm12[11]}}, ir.i.imm12};
  assign rs1_addr = ir.r.rs1;
  assign rs2_addr = ir.r.rs2;

  //--------------------------------------------------------------------
  // Operands and write back
  //--------------------------------------------------------------------

  assign opnd_b = is_addi ? imm : rs2_data;
  assign sum    = rs1_data + opnd_b;
  assign mul_a  = rs1_data;
  assign mul_b  = rs2_data;

  assign waddr = ir.r.rd;
  assign wdata = is_mul ? product : sum;
  // No-ops and x0 writes retire without a write
  assign rf_we = retire && (ir.r.rd != '0) && supported;

  // IR held from load through retire
  a_ir_stable: assert property (@(posedge clk) disable iff (reset)
    (state == blimp_pkg::s_mul || state == blimp_pkg::s_retire) |-> $stable(ir));

endmodule

`default_nettype wire

/* design/blimp_top.sv */
//----------------------------------------------------------------------
// Blimp core top level
// Control, execute, register file and multiplier on the memory port
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_top (
  input  logic                  clk,
  input  logic                  reset,
  output blimp_pkg::imem_req_t  imem_req,
  input  logic                  imem_req_ready,
  input  blimp_pkg::imem_resp_t imem_resp,
  output blimp_pkg::trace_t     trace
);

  //--------------------------------------------------------------------
  // Internal nets
  //--------------------------------------------------------------------

  blimp_pkg::ctrl_state_t           state;
  logic                             ir_load;
  logic                             mul_start;
  logic                             retire;
  logic [blimp_pkg::xlen-1:0]       pc;

  logic                             is_mul;
  logic [blimp_pkg::reg_addr_w-1:0] rs1_addr;
  logic [blimp_pkg::reg_addr_w-1:0] rs2_addr;
  logic [blimp_pkg::xlen-1:0]       rs1_data;
  logic [blimp_pkg::xlen-1:0]       rs2_data;
  logic [blimp_pkg::xlen-1:0]       mul_a;
  logic [blimp_pkg::xlen-1:0]       mul_b;
  logic                             rf_we;
  logic [blimp_pkg::reg_addr_w-1:0] waddr;
  logic [blimp_pkg::xlen-1:0]       wdata;

  logic                             mul_done;
  logic [blimp_pkg::xlen-1:0]       product;

  //--------------------------------------------------------------------
  // Instances
  //--------------------------------------------------------------------

  blimp_ctrl i_ctrl (
    .clk            (clk),
    .reset          (reset),
    .imem_req_ready (imem_req_ready),
    .resp_valid     (imem_resp.valid),
    .is_mul         (is_mul),
    .mul_done       (mul_done),
    .state          (state),
    .imem_req       (imem_req),
    .ir_load        (ir_load),
    .mul_start      (mul_start),
    .retire         (retire),
    .pc             (pc)
  );

  // Response data feeds the instruction register directly
  blimp_exec i_exec (
    .clk       (clk),
    .reset     (reset),
    .ir_load   (ir_load),
    .retire    (retire),
    .state     (state),
    .resp_data (imem_resp.data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .product   (product),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .is_mul    (is_mul),
    .mul_a     (mul_a),
    .mul_b     (mul_b),
    .rf_we     (rf_we),
    .waddr     (waddr),
    .wdata     (wdata)
  );

  blimp_regfile i_regfile (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (waddr),
    .wdata    (wdata)
  );

  blimp_mul i_mul (
    .clk     (clk),
    .reset   (reset),
    .start   (mul_start),
    .a       (mul_a),
    .b       (mul_b),
    .done    (mul_done),
    .product (product)
  );

  // Trace mirrors the register file write at retire
  always_comb begin
    trace.val   = retire;
    trace.pc    = pc;
    trace.waddr = waddr;
    trace.wdata = wdata;
    trace.wen   = rf_we;
  end

endmodule

`default_nettype wire

/* sim/blimp_checker.sv */
//----------------------------------------------------------------------
// Blimp core checker
// Snoops fetches, models the architectural state, compares each retire
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  blimp_pkg::imem_req_t  imem_req,
  input  logic                  imem_req_ready,
  input  blimp_pkg::imem_resp_t imem_resp,
  input  blimp_pkg::trace_t     trace,
  input  int unsigned           mul_first,
  input  int unsigned           zero_first,
  input  int unsigned           random_first,
  output int unsigned           mismatch_count,
  output int unsigned           protocol_count,
  output int unsigned           retired_count
);

  logic [31:0]       model_regs [0:31];
  logic [31:0]       model_pc;
  logic [31:0]       held_inst;
  bit                req_pending;
  bit                inst_held;
  bit                prev_reset;
  bit                started;
  int unsigned       cycle_count;
  int unsigned       resp_cycle;
  int unsigned       latency;
  string             name;
  blimp_pkg::trace_t want;

  function automatic string test_name(input int unsigned idx);
    if (idx < mul_first) begin
      return "add_chain";
    end
    if (idx < zero_first) begin
      return "mul";
    end
    if (idx < random_first) begin
      return "x0_noop";
    end
    return "random";
  endfunction

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------

  // Expected retire of one instruction against the model registers
  function automatic blimp_pkg::trace_t reference_retire(input logic [31:0] inst,
                                                         input logic [31:0] pc);
    blimp_pkg::trace_t r;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       imm;
    a   = model_regs[inst[19:15]];
    b   = model_regs[inst[24:20]];
    imm = {{20{inst[31]}}, inst[31:20]};
    r.val   = 1'b1;
    r.pc    = pc;
    r.waddr = inst[11:7];
    r.wdata = '0;
    r.wen   = 1'b0;
    if (inst[6:0] == blimp_pkg::op_reg && inst[14:12] == 3'b000) begin
      if (inst[31:25] == blimp_pkg::funct7_add) begin
        r.wdata = a + b;
        r.wen   = 1'b1;
      end else if (inst[31:25] == blimp_pkg::funct7_mul) begin
        // Low half is the same signed or unsigned
        r.wdata = a * b;
        r.wen   = 1'b1;
      end
    end else if (inst[6:0] == blimp_pkg::op_imm && inst[14:12] == 3'b000) begin
      r.wdata = a + imm;
      r.wen   = 1'b1;
    end
    if (inst[11:7] == 5'd0) begin
      r.wen = 1'b0;
    end
    return r;
  endfunction

  // Response strobe to trace pulse, in cycles
  function automatic int unsigned expected_latency(input logic [31:0] inst);
    if (inst[6:0] == blimp_pkg::op_reg && inst[14:12] == 3'b000
        && inst[31:25] == blimp_pkg::funct7_mul) begin
      return 2 + blimp_pkg::mul_steps;
    end
    return 2;
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("Mismatch %s %s at pc 0x%h: expected 0x%h, actual 0x%h",
             test, what, model_pc, expected, actual);
    mismatch_count++;
  endtask

  task automatic report_error(input string what);
    $display("Error: %s", what);
    protocol_count++;
  endtask

  //--------------------------------------------------------------------
  // Port watcher, sampled at the rising edge
  //--------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count++;
    if (started && (reset || prev_reset)) begin
      if (imem_req.valid !== 1'b0) begin
        report_error("request valid not low during or right after reset");
      end
      if (trace.val !== 1'b0) begin
        report_error("trace val not low during or right after reset");
      end
    end
    if (reset) begin
      model_pc    = blimp_pkg::reset_vector;
      req_pending = 1'b0;
      inst_held   = 1'b0;
      for (int k = 0; k < 32; k++) begin
        model_regs[k[4:0]] = '0;
      end
    end else begin
      name = test_name(retired_count);
      // Fetch must be the next sequential PC, one at a time
      if (imem_req.valid && imem_req_ready) begin
        if (req_pending || inst_held) begin
          report_error("new request while an instruction was still outstanding");
        end
        if (imem_req.addr !== model_pc) begin
          report_mismatch((retired_count == 0) ? "reset" : name, "fetch addr",
                          model_pc, imem_req.addr);
        end
        req_pending = 1'b1;
      end
      if (imem_resp.valid) begin
        if (!req_pending) begin
          report_error("response strobe with no request outstanding");
        end
        held_inst   = imem_resp.data;
        resp_cycle  = cycle_count;
        req_pending = 1'b0;
        inst_held   = 1'b1;
      end
      if (trace.val === 1'b1) begin
        if (!inst_held) begin
          report_error("trace pulse with no fetched instruction");
        end else begin
          want = reference_retire(held_inst, model_pc);
          if (trace.pc !== want.pc) begin
            report_mismatch(name, "pc", want.pc, trace.pc);
          end
          if (trace.wen !== want.wen) begin
            report_mismatch(name, "wen", {31'b0, want.wen}, {31'b0, trace.wen});
          end
          if (want.wen && trace.waddr !== want.waddr) begin
            report_mismatch(name, "waddr", {27'b0, want.waddr}, {27'b0, trace.waddr});
          end
          if (want.wen && trace.wdata !== want.wdata) begin
            report_mismatch(name, "wdata", want.wdata, trace.wdata);
          end
          latency = cycle_count - resp_cycle;
          if (latency != expected_latency(held_inst)) begin
            report_mismatch(name, "latency", expected_latency(held_inst), latency);
          end
          if (want.wen) begin
            model_regs[want.waddr] = want.wdata;
          end
          model_pc  = model_pc + 32'd4;
          inst_held = 1'b0;
          retired_count++;
        end
      end
    end
    prev_reset = reset;
    started    = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/blimp_tb.sv */
//----------------------------------------------------------------------
// Blimp core testbench
// Clock, reset, program image, memory model with random delays
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module blimp_tb;

  localparam int unsigned prog_max    = 512;
  localparam int unsigned reset_limit = 64;
  localparam int unsigned fetch_limit = 100;
  localparam int unsigned run_limit   = 40000;

  logic                  clk;
  logic                  reset;
  blimp_pkg::imem_req_t  imem_req;
  logic                  imem_req_ready;
  blimp_pkg::imem_resp_t imem_resp;
  blimp_pkg::trace_t     trace;

  // Program image, word 0 sits at reset_vector
  logic [31:0] prog [0:prog_max-1];
  int unsigned prog_len;
  int unsigned mul_first;
  int unsigned zero_first;
  int unsigned random_first;
  logic [15:0] lfsr_state;
  bit          mem_stuck;
  bit          run_timeout;
  int unsigned mismatch_count;
  int unsigned protocol_count;
  int unsigned retired_count;

  //--------------------------------------------------------------------
  // Random bits and instruction encoding
  //--------------------------------------------------------------------

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_add(input int rd, input int rs1, input int rs2);
    return {blimp_pkg::funct7_add, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], blimp_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_mul(input int rd, input int rs1, input int rs2);
    return {blimp_pkg::funct7_mul, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], blimp_pkg::op_reg};
  endfunction

  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], blimp_pkg::op_imm};
  endfunction

  task automatic append_inst(input logic [31:0] inst);
    prog[prog_len[8:0]] = inst;
    prog_len++;
  endtask

  //--------------------------------------------------------------------
  // Program image
  //--------------------------------------------------------------------

  task automatic build_program();
    int sel;
    int rd;
    int rs1;
    int rs2;
    int imm;
    prog_len = 0;
    // Dependent chain, negative immediates
    append_inst(enc_addi(1, 0, 5));
    append_inst(enc_addi(2, 1, -3));
    append_inst(enc_add(3, 1, 2));
    append_inst(enc_addi(4, 3, -100));
    append_inst(enc_add(5, 4, 4));
    append_inst(enc_addi(6, 5, 2047));
    append_inst(enc_addi(7, 6, -2048));
    // Positive, negative and large multiplies
    mul_first = prog_len;
    append_inst(enc_mul(8, 1, 2));
    append_inst(enc_mul(9, 4, 3));
    append_inst(enc_addi(10, 0, -1));
    append_inst(enc_mul(11, 10, 10));
    append_inst(enc_mul(12, 10, 3));
    append_inst(enc_addi(13, 0, 2047));
    append_inst(enc_mul(14, 13, 13));
    append_inst(enc_mul(15, 14, 14));
    append_inst(enc_mul(16, 15, 9));
    // x0 targets, then ecall, slti and sub as no-ops
    zero_first = prog_len;
    append_inst(enc_addi(0, 1, 9));
    append_inst(enc_add(0, 1, 2));
    append_inst(enc_mul(0, 3, 3));
    append_inst(enc_add(17, 0, 0));
    append_inst(enc_addi(18, 0, 7));
    append_inst(32'h0000_0073);
    append_inst({12'd5, 5'd1, 3'b010, 5'd19, blimp_pkg::op_imm});
    append_inst({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd20, blimp_pkg::op_reg});
    append_inst(enc_add(21, 0, 1));
    // Every register gets a value before the random mix reads it
    random_first = prog_len;
    for (int k = 1; k < 32; k++) begin
      imm = rand_bits(12);
      append_inst(enc_addi(k, 0, imm));
    end
    for (int n = 0; n < 200; n++) begin
      sel = rand_bits(2);
      rd  = rand_bits(5);
      rs1 = rand_bits(5);
      rs2 = rand_bits(5);
      imm = rand_bits(12);
      case (sel)
        0:       append_inst(enc_add(rd, rs1, rs2));
        1:       append_inst(enc_mul(rd, rs1, rs2));
        default: append_inst(enc_addi(rd, rs1, imm));
      endcase
    end
  endtask

  // Words past the program hash the address into a custom-0 opcode
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] index;
    logic [31:0] mix;
    index = (addr - blimp_pkg::reset_vector) >> 2;
    if (addr >= blimp_pkg::reset_vector && index < prog_len) begin
      return prog[index[8:0]];
    end
    mix = addr ^ {addr[15:0], addr[31:16]} ^ 32'hA5C3_0F96;
    return {mix[31:7], 7'b0001011};
  endfunction

  //--------------------------------------------------------------------
  // Clock, DUT and checker
  //--------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  blimp_top i_blimp_top (
    .clk            (clk),
    .reset          (reset),
    .imem_req       (imem_req),
    .imem_req_ready (imem_req_ready),
    .imem_resp      (imem_resp),
    .trace          (trace)
  );

  blimp_checker i_checker (
    .clk            (clk),
    .reset          (reset),
    .imem_req       (imem_req),
    .imem_req_ready (imem_req_ready),
    .imem_resp      (imem_resp),
    .trace          (trace),
    .mul_first      (mul_first),
    .zero_first     (zero_first),
    .random_first   (random_first),
    .mismatch_count (mismatch_count),
    .protocol_count (protocol_count),
    .retired_count  (retired_count)
  );

  //--------------------------------------------------------------------
  // Memory model
  //--------------------------------------------------------------------

  initial begin : memory_model
    int unsigned waited;
    int unsigned delay;
    logic [31:0] addr;
    imem_req_ready <= 1'b0;
    imem_resp      <= '0;
    waited = 0;
    while (reset !== 1'b0 && waited < reset_limit) begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("Error: reset was not released within %0d cycles", reset_limit);
      mem_stuck = 1'b1;
    end
    while (!mem_stuck) begin
      waited = 0;
      @(posedge clk);
      while (!imem_req.valid && waited < fetch_limit) begin
        @(posedge clk);
        waited++;
      end
      if (!imem_req.valid) begin
        $display("Error: core issued no fetch request within %0d cycles", fetch_limit);
        mem_stuck = 1'b1;
      end else begin
        // Request delay with ready low; valid must hold meanwhile
        delay = rand_bits(2);
        repeat (delay) @(posedge clk);
        imem_req_ready <= 1'b1;
        @(posedge clk);
        addr = imem_req.addr;
        imem_req_ready <= 1'b0;
        // Response delay, then a one-cycle strobe
        delay = rand_bits(2);
        repeat (delay) @(posedge clk);
        imem_resp <= {1'b1, fetch_word(addr)};
        @(posedge clk);
        imem_resp <= '0;
      end
    end
  end

  //--------------------------------------------------------------------
  // Reset, run and final report
  //--------------------------------------------------------------------

  initial begin
    int unsigned waited;
    reset      <= 1'b1;
    lfsr_state = 16'd27351;
    build_program();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    waited = 0;
    while (retired_count < prog_len && waited < run_limit && !mem_stuck) begin
      @(negedge clk);
      waited++;
    end
    run_timeout = !mem_stuck && (retired_count < prog_len);
    if (run_timeout) begin
      $display("Error: run timed out with %0d of %0d instructions retired",
               retired_count, prog_len);
    end
    $display("Summary: %0d mismatches, %0d protocol errors, %0d timeouts, %0d retired",
             mismatch_count, protocol_count, int'(mem_stuck) + int'(run_timeout),
             retired_count);
    if (mismatch_count == 0 && protocol_count == 0 && !mem_stuck && !run_timeout) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
design/blimp_pkg.sv
design/blimp_ctrl.sv
design/blimp_mul.sv
design/blimp_regfile.sv
design/blimp_exec.sv
design/blimp_top.sv
sim/blimp_checker.sv
sim/blimp_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the blimp core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module blimp_tb -f list.f -o blimp_sim

./obj_dir/blimp_sim | tee sim.log

# Verdict comes from the log
if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "simulation did not report a pass, see sim.log" >&2
exit 1
